/* bitonic_merge_16.sv */
`default_nettype none

module bitonic_merge_16 (
   input  merge_pkg::tuple_t i_lo,
   input  merge_pkg::tuple_t i_hi,
   output merge_pkg::tuple_t o_low,
   output merge_pkg::tuple_t o_high
);

   // Stage 0 is the bitonic input, stage MERGE_LEVELS is fully sorted.
   merge_pkg::key_t stg [merge_pkg::MERGE_LEVELS+1][2*merge_pkg::TUPLE_KEYS];

   genvar k;
   genvar lvl;
   genvar j;

   generate
      for (k = 0; k < merge_pkg::TUPLE_KEYS; k++) begin : g_in
         assign stg[0][k] = i_lo[k*merge_pkg::KEY_W +: merge_pkg::KEY_W];
         // Reversing the upper tuple makes the sixteen keys rise then fall.
         assign stg[0][merge_pkg::TUPLE_KEYS+k] =
            i_hi[(merge_pkg::TUPLE_KEYS-1-k)*merge_pkg::KEY_W +: merge_pkg::KEY_W];
      end

      for (lvl = 0; lvl < merge_pkg::MERGE_LEVELS; lvl++) begin : g_lvl
         localparam int DIST = merge_pkg::TUPLE_KEYS >> lvl;

         for (j = 0; j < merge_pkg::TUPLE_KEYS; j++) begin : g_cx
            localparam int LO = (j / DIST) * 2 * DIST + (j % DIST);
            localparam int HI = LO + DIST;

            logic swap;

            assign swap = stg[lvl][LO] > stg[lvl][HI];
            assign stg[lvl+1][LO] = swap ? stg[lvl][HI] : stg[lvl][LO];
            assign stg[lvl+1][HI] = swap ? stg[lvl][LO] : stg[lvl][HI];
         end
      end

      for (k = 0; k < merge_pkg::TUPLE_KEYS; k++) begin : g_out
         assign o_low[k*merge_pkg::KEY_W +: merge_pkg::KEY_W] =
            stg[merge_pkg::MERGE_LEVELS][k];
         assign o_high[k*merge_pkg::KEY_W +: merge_pkg::KEY_W] =
            stg[merge_pkg::MERGE_LEVELS][merge_pkg::TUPLE_KEYS+k];
      end
   endgenerate

endmodule

`default_nettype wire

/* credit_counter.sv */
`default_nettype none

module credit_counter (
   input  wire  i_clk,
   input  wire  i_rst_n,
   input  wire  i_issue,
   input  wire  i_return,
   output logic o_credit_ok
);

   logic [merge_pkg::CREDIT_W-1:0] count_q;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         count_q <= merge_pkg::CREDIT_W'(merge_pkg::OUT_CREDITS);
      end else begin
         unique case ({i_issue, i_return})
            2'b10:   count_q <= count_q - merge_pkg::CREDIT_W'(1);
            2'b01:   count_q <= count_q + merge_pkg::CREDIT_W'(1);
            default: count_q <= count_q;             // Issue and return cancel out.
         endcase
      end
   end

   assign o_credit_ok = (count_q != '0);

   // The downstream never returns more credits than beats it received.
   a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      count_q <= merge_pkg::CREDIT_W'(merge_pkg::OUT_CREDITS));

   a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_issue |-> count_q != '0);

endmodule

`default_nettype wire

/* merge_ctrl.sv */
`default_nettype none

module merge_ctrl (
   input  wire                  i_clk,
   input  wire                  i_rst_n,
   input  merge_pkg::tuple_t    i_head_a,
   input  merge_pkg::tuple_t    i_head_b,
   input  wire                  i_empty_a,
   input  wire                  i_empty_b,
   input  wire                  i_credit_ok,
   output logic                 o_deq_a,
   output logic                 o_deq_b,
   output merge_pkg::merge_op_t o_op,
   output logic                 o_issue
);

   merge_pkg::ctrl_state_t state_q;
   merge_pkg::ctrl_state_t state_d;
   merge_pkg::key_t        key_a;
   merge_pkg::key_t        key_b;
   logic                   a_term;
   logic                   b_term;
   logic                   a_data;
   logic                   b_data;
   logic                   a_first;

   assign key_a   = i_head_a[merge_pkg::KEY_W-1:0];
   assign key_b   = i_head_b[merge_pkg::KEY_W-1:0];
   assign a_term  = !i_empty_a && (key_a == '0);
   assign b_term  = !i_empty_b && (key_b == '0);
   assign a_data  = !i_empty_a && (key_a != '0);
   assign b_data  = !i_empty_b && (key_b != '0);
   assign a_first = key_a <= key_b;                // Ties go to A.

   always_comb begin
      state_d = state_q;
      o_deq_a = 1'b0;
      o_deq_b = 1'b0;
      o_op    = '0;
      unique case (state_q)
         merge_pkg::EMPTY: begin
            if (a_term && b_term) begin
               if (i_credit_ok) begin
                  o_deq_a   = 1'b1;
                  o_deq_b   = 1'b1;
                  o_op.term = 1'b1;            // Both runs were empty.
               end
            end else if (a_data && (!b_data || a_first)) begin
               o_deq_a   = 1'b1;
               o_op.load = 1'b1;
               state_d   = merge_pkg::MERGE;
            end else if (b_data) begin
               o_deq_b    = 1'b1;
               o_op.load  = 1'b1;
               o_op.sel_b = 1'b1;
               state_d    = merge_pkg::MERGE;
            end
         end
         merge_pkg::MERGE: begin
            if (a_term && b_term) begin
               state_d = merge_pkg::FLUSH;
            end else if (i_credit_ok) begin
               if (a_data && (b_term || (b_data && a_first))) begin
                  o_deq_a    = 1'b1;
                  o_op.merge = 1'b1;
               end else if (b_data && (a_term || a_data)) begin
                  o_deq_b    = 1'b1;
                  o_op.merge = 1'b1;
                  o_op.sel_b = 1'b1;
               end
            end
         end
         merge_pkg::FLUSH: begin
            if (i_credit_ok) begin
               o_op.flush = 1'b1;
               state_d    = merge_pkg::TERM;
            end
         end
         merge_pkg::TERM: begin
            if (i_credit_ok) begin
               o_deq_a   = 1'b1;               // Both heads still hold their terminators.
               o_deq_b   = 1'b1;
               o_op.term = 1'b1;
               state_d   = merge_pkg::EMPTY;
            end
         end
         default: state_d = merge_pkg::EMPTY;
      endcase
   end

   assign o_issue = o_op.merge | o_op.flush | o_op.term;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= merge_pkg::EMPTY;
      end else begin
         state_q <= state_d;
      end
   end

   a_pop_nonempty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_deq_a |-> !i_empty_a) and (o_deq_b |-> !i_empty_b));

endmodule

`default_nettype wire

/* merge_pkg.sv */
`default_nettype none

package merge_pkg;

   localparam int KEY_W        = 32;
   localparam int TUPLE_KEYS   = 8;
   localparam int TUPLE_W      = KEY_W * TUPLE_KEYS;
   localparam int FIFO_DEPTH   = 4;            // Also the credits each source starts with.
   localparam int PTR_W        = 2;
   localparam int FIFO_CNT_W   = 3;
   localparam int OUT_CREDITS  = 4;
   localparam int CREDIT_W     = 3;
   localparam int MERGE_LEVELS = 4;            // log2 of the sixteen keys in the network.

   typedef logic [KEY_W-1:0]   key_t;
   typedef logic [TUPLE_W-1:0] tuple_t;        // Key 0 in the low bits is the smallest.

   typedef struct packed {
      logic   valid;
      tuple_t tuple;
   } in_beat_t;

   typedef struct packed {
      logic   valid;
      logic   last;                            // Set only on a terminator beat.
      tuple_t tuple;
   } out_beat_t;

   typedef enum logic [1:0] {
      EMPTY,
      MERGE,
      FLUSH,
      TERM
   } ctrl_state_t;

   typedef struct packed {
      logic load;                              // Popped tuple goes straight to the held register.
      logic merge;
      logic sel_b;                             // Popped tuple comes from input B.
      logic flush;
      logic term;
   } merge_op_t;

endpackage

`default_nettype wire

/* run_merger_top.sv */
`default_nettype none

module run_merger_top (
   input  wire                  i_clk,
   input  wire                  i_rst_n,
   input  merge_pkg::in_beat_t  i_a,
   input  merge_pkg::in_beat_t  i_b,
   output logic                 o_a_credit,
   output logic                 o_b_credit,
   output merge_pkg::out_beat_t o_out,
   input  wire                  i_out_credit
);

   merge_pkg::tuple_t    head_a;
   merge_pkg::tuple_t    head_b;
   logic                 empty_a;
   logic                 empty_b;
   logic                 deq_a;
   logic                 deq_b;
   logic                 issue;
   logic                 credit_ok;
   merge_pkg::merge_op_t op;

   tuple_fifo u_fifo_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_wr    (i_a),
      .i_deq   (deq_a),
      .o_head  (head_a),
      .o_empty (empty_a)
   );

   tuple_fifo u_fifo_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_wr    (i_b),
      .i_deq   (deq_b),
      .o_head  (head_b),
      .o_empty (empty_b)
   );

   merge_ctrl u_merge_ctrl (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_head_a    (head_a),
      .i_head_b    (head_b),
      .i_empty_a   (empty_a),
      .i_empty_b   (empty_b),
      .i_credit_ok (credit_ok),
      .o_deq_a     (deq_a),
      .o_deq_b     (deq_b),
      .o_op        (op),
      .o_issue     (issue)
   );

   credit_counter u_credit_counter (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_issue     (issue),
      .i_return    (i_out_credit),
      .o_credit_ok (credit_ok)
   );

   tuple_merge_unit u_tuple_merge_unit (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_op     (op),
      .i_head_a (head_a),
      .i_head_b (head_b),
      .o_out    (o_out)
   );

   assign o_a_credit = deq_a;                   // Each pop frees one slot at the source.
   assign o_b_credit = deq_b;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the run merger testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_run_merger -o tb_run_merger
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_run_merger > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
   exit 0
fi
exit 1

/* sim.f */
+incdir+.
merge_pkg.sv
tuple_fifo.sv
bitonic_merge_16.sv
tuple_merge_unit.sv
merge_ctrl.sv
credit_counter.sv
run_merger_top.sv
tb_run_merger.sv

/* tb_merge_ref.svh */
`ifndef TB_MERGE_REF_SVH
`define TB_MERGE_REF_SVH

// Galois form of x^32 + x^22 + x^2 + x + 1, shifting right.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic int unsigned rand_bits(input int n);
   int unsigned v;
   v = 0;
   for (int i = 0; i < n; i++) begin
      v = (v << 1) | 32'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
   end
   return v;
endfunction

// Builds one nondecreasing run of nonzero keys for a source and closes it with a terminator.
task automatic gen_run(input int n_tuples, input int start_key, input int max_step,
                       input bit side);
   merge_pkg::tuple_t t;
   merge_pkg::key_t   k;
   k = merge_pkg::key_t'(start_key);
   for (int i = 0; i < n_tuples; i++) begin
      for (int j = 0; j < merge_pkg::TUPLE_KEYS; j++) begin
         t[j*merge_pkg::KEY_W +: merge_pkg::KEY_W] = k;
         if (side) b_keys.push_back(k);
         else a_keys.push_back(k);
         k = k + merge_pkg::key_t'(rand_bits(8) % (max_step + 1));
      end
      if (side) b_src.push_back(t);
      else a_src.push_back(t);
   end
   if (side) b_src.push_back('0);
   else a_src.push_back('0);
   wd_limit += 200 * (n_tuples + 1);
endtask

// Expected output of one run pair: all keys sorted, cut into tuples, then a terminator.
function automatic void ref_merge();
   merge_pkg::key_t      all [$];
   merge_pkg::key_t      tmp;
   merge_pkg::out_beat_t beat;
   int                   i;
   int                   j;
   all = a_keys;
   foreach (b_keys[n]) all.push_back(b_keys[n]);
   for (i = 1; i < all.size(); i++) begin
      tmp = all[i];
      j = i - 1;
      while (j >= 0 && all[j] > tmp) begin
         all[j+1] = all[j];
         j--;
      end
      all[j+1] = tmp;
   end
   for (i = 0; i < all.size(); i += merge_pkg::TUPLE_KEYS) begin
      beat = '0;
      beat.valid = 1'b1;
      for (j = 0; j < merge_pkg::TUPLE_KEYS; j++) begin
         beat.tuple[j*merge_pkg::KEY_W +: merge_pkg::KEY_W] = all[i+j];
      end
      exp_q.push_back(beat);
   end
   beat = '0;
   beat.valid = 1'b1;
   beat.last  = 1'b1;
   exp_q.push_back(beat);
   a_keys.delete();
   b_keys.delete();
endfunction

`endif

/* tb_run_merger.sv */
`default_nettype none

module tb_run_merger;

   logic                 clk = 1'b0;
   logic                 rst_n = 1'b0;
   merge_pkg::in_beat_t  a_beat = '0;
   merge_pkg::in_beat_t  b_beat = '0;
   logic                 out_credit = 1'b0;
   logic                 a_credit;
   logic                 b_credit;
   merge_pkg::out_beat_t out_beat;

   merge_pkg::tuple_t    a_src [$];
   merge_pkg::tuple_t    b_src [$];
   merge_pkg::key_t      a_keys [$];
   merge_pkg::key_t      b_keys [$];
   merge_pkg::out_beat_t exp_q [$];
   merge_pkg::out_beat_t exp_beat;
   logic [31:0]          lfsr_state = 32'd97;
   string                cur_test = "reset";
   logic                 full_rate = 1'b0;
   logic                 withhold = 1'b0;
   int                   a_used = 0;
   int                   b_used = 0;
   int                   a_returned = 0;
   int                   b_returned = 0;
   int                   beats_seen = 0;
   int                   credits_sent = 0;
   int                   errors = 0;
   int                   tests_run = 0;
   int                   tests_failed = 0;
   int                   wd_limit = 50;
   int                   wd_cycles = 0;

   `include "tb_merge_ref.svh"

   run_merger_top u_run_merger_top (
      .i_clk        (clk),
      .i_rst_n      (rst_n),
      .i_a          (a_beat),
      .i_b          (b_beat),
      .o_a_credit   (a_credit),
      .o_b_credit   (b_credit),
      .o_out        (out_beat),
      .i_out_credit (out_credit)
   );

   always #2 clk = ~clk;

   // The DUT outputs are sampled on the falling edge before the next inputs are driven.
   always @(negedge clk) begin
      if (rst_n && out_beat.valid) begin
         beats_seen++;
         if (beats_seen > merge_pkg::OUT_CREDITS + credits_sent) begin
            $display("%s: output beat %0d was sent without a downstream credit",
                     cur_test, beats_seen);
            errors++;
         end
         if (exp_q.size() == 0) begin
            $display("%s: an output beat arrived when none was expected", cur_test);
            errors++;
         end else begin
            exp_beat = exp_q.pop_front();
            if (out_beat.last != exp_beat.last || out_beat.tuple != exp_beat.tuple) begin
               $display("[FAIL] %s expected last=%0b tuple=%h actual last=%0b tuple=%h",
                        cur_test, exp_beat.last, exp_beat.tuple,
                        out_beat.last, out_beat.tuple);
               errors++;
            end
         end
      end
      a_beat     = '0;
      b_beat     = '0;
      out_credit = 1'b0;
      if (rst_n) begin
         if (a_src.size() != 0 && a_used < merge_pkg::FIFO_DEPTH + a_returned
             && (full_rate || rand_bits(2) != 0)) begin
            a_beat.valid = 1'b1;
            a_beat.tuple = a_src.pop_front();
            a_used++;
         end
         if (b_src.size() != 0 && b_used < merge_pkg::FIFO_DEPTH + b_returned
             && (full_rate || rand_bits(2) != 0)) begin
            b_beat.valid = 1'b1;
            b_beat.tuple = b_src.pop_front();
            b_used++;
         end
         // Downstream hands back one credit per beat it has taken, after a random delay.
         if (!withhold && credits_sent < beats_seen && (full_rate || rand_bits(2) == 0)) begin
            out_credit = 1'b1;
            credits_sent++;
         end
         // The slot frees at the coming edge and can be refilled from the next cycle on.
         if (a_credit) a_returned++;
         if (b_credit) b_returned++;
      end
   end

   initial begin
      while (wd_cycles < wd_limit) begin
         @(negedge clk);
         wd_cycles++;
      end
      $display("Watchdog expired after %0d cycles with %0d output beats still missing",
               wd_cycles, exp_q.size());
      $display("TESTS FAILED");
      $finish;
   end

   // Credits are withheld for hold_cycles, then the test runs until every beat has arrived.
   task automatic run_test(input string name, input int hold_cycles);
      int errors_before;
      cur_test      = name;
      errors_before = errors;
      withhold      = (hold_cycles > 0);
      repeat (hold_cycles) @(posedge clk);
      withhold = 1'b0;
      while (a_src.size() != 0 || b_src.size() != 0 || exp_q.size() != 0) @(posedge clk);
      @(posedge clk);
      tests_run++;
      if (errors == errors_before) begin
         $display("[PASS] %s", name);
      end else begin
         $display("%s finished with %0d errors", name, errors - errors_before);
         tests_failed++;
      end
      @(posedge clk);
   endtask

   initial begin
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(posedge clk);
      gen_run(int'(1 + rand_bits(3) % 6), int'(1 + rand_bits(8)), 50, 1'b0);
      gen_run(int'(1 + rand_bits(3) % 6), int'(1 + rand_bits(8)), 50, 1'b1);
      ref_merge();
      run_test("single_run", 0);
      gen_run(0, 1, 50, 1'b0);
      gen_run(3, int'(1 + rand_bits(8)), 50, 1'b1);
      ref_merge();
      run_test("a_terminator_only", 0);
      gen_run(0, 1, 50, 1'b0);
      gen_run(0, 1, 50, 1'b1);
      ref_merge();
      run_test("both_terminators_only", 0);
      gen_run(4, 5, 1, 1'b0);                  // Equal first keys and many repeats.
      gen_run(4, 5, 1, 1'b1);
      ref_merge();
      run_test("duplicate_keys", 0);
      gen_run(5, int'(1 + rand_bits(8)), 30, 1'b0);
      gen_run(5, int'(1 + rand_bits(8)), 30, 1'b1);
      ref_merge();
      run_test("credit_withhold", 80);
      full_rate = 1'b1;
      for (int r = 0; r < 3; r++) begin
         gen_run(3, int'(1 + rand_bits(8)), 40, 1'b0);
         gen_run(2 + r, int'(1 + rand_bits(8)), 40, 1'b1);
         ref_merge();
      end
      run_test("back_to_back", 0);
      $display("%0d tests run, %0d failed, %0d errors in total", tests_run, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tuple_fifo.sv */
`default_nettype none

module tuple_fifo (
   input  wire                 i_clk,
   input  wire                 i_rst_n,
   input  merge_pkg::in_beat_t i_wr,
   input  wire                 i_deq,
   output merge_pkg::tuple_t   o_head,
   output logic                o_empty
);

   logic [merge_pkg::PTR_W-1:0]      rd_ptr_q;
   logic [merge_pkg::PTR_W-1:0]      wr_ptr_q;
   logic [merge_pkg::PTR_W-1:0]      rd_ptr_d;
   logic [merge_pkg::FIFO_CNT_W-1:0] count_q;
   merge_pkg::tuple_t                mem_q [merge_pkg::FIFO_DEPTH];
   merge_pkg::tuple_t                head_q;

   assign rd_ptr_d = i_deq ? rd_ptr_q + merge_pkg::PTR_W'(1) : rd_ptr_q;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         rd_ptr_q <= rd_ptr_d;
         if (i_wr.valid) begin
            wr_ptr_q <= wr_ptr_q + merge_pkg::PTR_W'(1);
         end
         unique case ({i_wr.valid, i_deq})
            2'b10:   count_q <= count_q + merge_pkg::FIFO_CNT_W'(1);
            2'b01:   count_q <= count_q - merge_pkg::FIFO_CNT_W'(1);
            default: count_q <= count_q;
         endcase
      end
   end

   // The head register tracks the entry at the next read pointer, bypassing a write into it.
   always_ff @(posedge i_clk) begin
      if (i_wr.valid) begin
         mem_q[wr_ptr_q] <= i_wr.tuple;
      end
      head_q <= (i_wr.valid && wr_ptr_q == rd_ptr_d) ? i_wr.tuple : mem_q[rd_ptr_d];
   end

   assign o_head  = head_q;
   assign o_empty = (count_q == '0);

   // The source only writes while it holds a credit, so a full FIFO is never written.
   a_no_overrun: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wr.valid |-> count_q != merge_pkg::FIFO_CNT_W'(merge_pkg::FIFO_DEPTH));

   a_no_underrun: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_deq |-> count_q != '0);

endmodule

`default_nettype wire

/* tuple_merge_unit.sv */
`default_nettype none

module tuple_merge_unit (
   input  wire                  i_clk,
   input  wire                  i_rst_n,
   input  merge_pkg::merge_op_t i_op,
   input  merge_pkg::tuple_t    i_head_a,
   input  merge_pkg::tuple_t    i_head_b,
   output merge_pkg::out_beat_t o_out
);

   merge_pkg::tuple_t head;
   merge_pkg::tuple_t held_q;
   merge_pkg::tuple_t net_low;
   merge_pkg::tuple_t net_high;
   merge_pkg::tuple_t out_tuple_q;
   logic              out_valid_q;
   logic              out_last_q;

   assign head = i_op.sel_b ? i_head_b : i_head_a;

   bitonic_merge_16 u_bitonic_merge_16 (
      .i_lo   (held_q),
      .i_hi   (head),
      .o_low  (net_low),
      .o_high (net_high)
   );

   // The held tuple changes at the pop edge so the next pop can merge against it.
   always_ff @(posedge i_clk) begin
      if (i_op.load) begin
         held_q <= head;
      end else if (i_op.merge) begin
         held_q <= net_high;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_valid_q <= 1'b0;
         out_last_q  <= 1'b0;
      end else begin
         out_valid_q <= i_op.merge | i_op.flush | i_op.term;
         out_last_q  <= i_op.term;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_op.merge) begin
         out_tuple_q <= net_low;
      end else if (i_op.flush) begin
         out_tuple_q <= held_q;
      end else if (i_op.term) begin
         out_tuple_q <= '0;                       // Zero key 0 marks the terminator.
      end
   end

   always_comb begin
      o_out.valid = out_valid_q;
      o_out.last  = out_last_q;
      o_out.tuple = out_tuple_q;
   end

endmodule

`default_nettype wire
